/* design/issue_ctrl.sv */
`timescale 1ns/1ns

module issue_ctrl #(
    parameter int STALL_LIMIT = 16
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  issue_pkg::decode_t [issue_pkg::num_warps-1:0] head,
    input  logic [issue_pkg::num_warps-1:0]               head_hazard,
    input  logic                                          issue_ready,
    output issue_pkg::wid_t                               sel_wid,
    output logic                                          issue_fire,
    output logic                                          issue_valid,
    output logic                                          stall_timeout
);

    localparam int cnt_w = $clog2(STALL_LIMIT + 1);

    logic [issue_pkg::num_warps-1:0] eligible;
    logic [issue_pkg::num_warps-1:0] stalled;
    logic [issue_pkg::num_warps-1:0] timed_out;

    issue_pkg::wid_t last_wid;
    issue_pkg::wid_t rr_wid;
    issue_pkg::wid_t cand;
    issue_pkg::wid_t locked_wid;
    logic            locked;
    logic            found;

    logic [cnt_w-1:0] stall_cnt [issue_pkg::num_warps];

    always_comb begin
        for (int w = 0; w < issue_pkg::num_warps; w++) begin
            eligible[w] = head[w].valid && !head_hazard[w];
            stalled[w]  = head[w].valid && head_hazard[w];
        end
    end

    // search starts one past the warp that issued last
    always_comb begin
        rr_wid = last_wid;
        found  = 1'b0;
        cand   = last_wid;
        for (int i = 1; i <= issue_pkg::num_warps; i++) begin
            cand = issue_pkg::wid_t'((int'(last_wid) + i) % issue_pkg::num_warps);
            if (!found && eligible[cand]) begin
                found  = 1'b1;
                rr_wid = cand;
            end
        end
    end

    // a presented instruction keeps its warp until the consumer takes it
    assign sel_wid     = locked ? locked_wid : rr_wid;
    assign issue_valid = eligible[sel_wid];
    assign issue_fire  = issue_valid && issue_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_wid   <= issue_pkg::wid_t'(issue_pkg::num_warps - 1);
            locked     <= 1'b0;
            locked_wid <= '0;
        end else begin
            if (issue_fire) begin
                last_wid <= sel_wid;
                locked   <= 1'b0;
            end else if (issue_valid) begin
                locked     <= 1'b1;
                locked_wid <= sel_wid;
            end
        end
    end

    // watchdog, one saturating counter per warp that only an issue clears
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < issue_pkg::num_warps; w++) begin
                stall_cnt[w] <= '0;
            end
        end else begin
            for (int w = 0; w < issue_pkg::num_warps; w++) begin
                if (issue_fire && (sel_wid == issue_pkg::wid_t'(w))) begin
                    stall_cnt[w] <= '0;
                end else if (stalled[w] && (stall_cnt[w] != cnt_w'(STALL_LIMIT))) begin
                    stall_cnt[w] <= stall_cnt[w] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < issue_pkg::num_warps; w++) begin
            timed_out[w] = (stall_cnt[w] == cnt_w'(STALL_LIMIT));
        end
    end

    assign stall_timeout = |timed_out;

endmodule

/* design/issue_pkg.sv */
package issue_pkg;

    localparam int num_warps  = 4;
    localparam int num_regs   = 32;
    localparam int data_width = 32;
    localparam int wid_w      = $clog2(num_warps);
    localparam int reg_idx_w  = $clog2(num_regs);

    typedef logic [wid_w-1:0]      wid_t;
    typedef logic [reg_idx_w-1:0]  reg_idx_t;
    typedef logic [num_regs-1:0]   reg_mask_t;
    typedef logic [data_width-1:0] data_t;

    // the second source field is either a register index or an immediate
    // that the decoder has already sign-extended to the full width
    typedef union packed {
        struct packed {
            logic [data_width-reg_idx_w-1:0] unused;
            reg_idx_t                        idx;
        } rs2;
        logic signed [data_width-1:0] imm;
    } src_b_u;

    typedef struct packed {
        logic      valid;
        wid_t      wid;
        logic [31:0] pc;
        reg_idx_t  rd;
        logic      wb;
        reg_idx_t  rs1;
        logic      use_imm;
        src_b_u    src_b;
        // registers read by the instruction, plus rd when wb is set
        reg_mask_t used_regs;
    } decode_t;

    typedef struct packed {
        logic     valid;
        wid_t     wid;
        reg_idx_t rd;
        data_t    data;
    } writeback_t;

    typedef struct packed {
        logic        valid;
        wid_t        wid;
        logic [31:0] pc;
        reg_idx_t    rd;
        logic        wb;
        data_t       operand_a;
        data_t       operand_b;
    } issue_t;

endpackage

/* design/issue_stage.sv */
`timescale 1ns/1ns

module issue_stage #(
    parameter int IBUF_DEPTH  = 4,
    parameter int STALL_LIMIT = 16
) (
    input  logic                  clk,
    input  logic                  reset,
    input  issue_pkg::decode_t    decode_in,
    output logic                  decode_ready,
    input  issue_pkg::writeback_t writeback,
    output issue_pkg::issue_t     issue_out,
    input  logic                  issue_ready,
    output logic                  stall_timeout
);

    issue_pkg::decode_t [issue_pkg::num_warps-1:0] head;
    logic [issue_pkg::num_warps-1:0]               head_hazard;

    issue_pkg::wid_t    sel_wid;
    issue_pkg::decode_t sel_head;
    issue_pkg::data_t   operand_a;
    issue_pkg::data_t   operand_b;
    logic               issue_fire;
    logic               issue_valid;

    assign sel_head = head[sel_wid];

    warp_ibuffer #(
        .IBUF_DEPTH (IBUF_DEPTH)
    ) u_warp_ibuffer (
        .clk          (clk),
        .reset        (reset),
        .decode_in    (decode_in),
        .decode_ready (decode_ready),
        .pop          (issue_fire),
        .pop_wid      (sel_wid),
        .head         (head)
    );

    scoreboard u_scoreboard (
        .clk         (clk),
        .reset       (reset),
        .head        (head),
        .reserve     (issue_fire),
        .reserve_wid (sel_wid),
        .writeback   (writeback),
        .head_hazard (head_hazard)
    );

    operand_regfile u_operand_regfile (
        .clk       (clk),
        .reset     (reset),
        .rd_wid    (sel_wid),
        .rs1       (sel_head.rs1),
        .src_b     (sel_head.src_b),
        .use_imm   (sel_head.use_imm),
        .writeback (writeback),
        .operand_a (operand_a),
        .operand_b (operand_b)
    );

    issue_ctrl #(
        .STALL_LIMIT (STALL_LIMIT)
    ) u_issue_ctrl (
        .clk           (clk),
        .reset         (reset),
        .head          (head),
        .head_hazard   (head_hazard),
        .issue_ready   (issue_ready),
        .sel_wid       (sel_wid),
        .issue_fire    (issue_fire),
        .issue_valid   (issue_valid),
        .stall_timeout (stall_timeout)
    );

    always_comb begin
        issue_out.valid     = issue_valid;
        issue_out.wid       = sel_wid;
        issue_out.pc        = sel_head.pc;
        issue_out.rd        = sel_head.rd;
        issue_out.wb        = sel_head.wb;
        issue_out.operand_a = operand_a;
        issue_out.operand_b = operand_b;
    end

endmodule

/* design/operand_regfile.sv */
`timescale 1ns/1ns

module operand_regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  issue_pkg::wid_t       rd_wid,
    input  issue_pkg::reg_idx_t   rs1,
    input  issue_pkg::src_b_u     src_b,
    input  logic                  use_imm,
    input  issue_pkg::writeback_t writeback,
    output issue_pkg::data_t      operand_a,
    output issue_pkg::data_t      operand_b
);

    issue_pkg::data_t regs [issue_pkg::num_warps][issue_pkg::num_regs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < issue_pkg::num_warps; w++) begin
                for (int r = 0; r < issue_pkg::num_regs; r++) begin
                    regs[w][r] <= '0;
                end
            end
        end else if (writeback.valid) begin
            regs[writeback.wid][writeback.rd] <= writeback.data;
        end
    end

    // both reads are asynchronous so the selected head sees its operands
    // in the same cycle it is chosen
    assign operand_a = regs[rd_wid][rs1];

    always_comb begin
        if (use_imm) begin
            operand_b = src_b.imm;
        end else begin
            operand_b = regs[rd_wid][src_b.rs2.idx];
        end
    end

endmodule

/* design/scoreboard.sv */
`timescale 1ns/1ns

module scoreboard (
    input  logic                                          clk,
    input  logic                                          reset,
    input  issue_pkg::decode_t [issue_pkg::num_warps-1:0] head,
    input  logic                                          reserve,
    input  issue_pkg::wid_t                               reserve_wid,
    input  issue_pkg::writeback_t                         writeback,
    output logic [issue_pkg::num_warps-1:0]               head_hazard
);

    issue_pkg::reg_mask_t [issue_pkg::num_warps-1:0] inuse_regs;

    issue_pkg::decode_t res_head;
    logic               reserve_reg;
    logic               release_reg;

    assign res_head    = head[reserve_wid];
    assign reserve_reg = reserve && res_head.wb;
    assign release_reg = writeback.valid;

    // used_regs already covers rd when wb is set, so one mask check
    // catches both read-after-write and write-after-write
    always_comb begin
        for (int w = 0; w < issue_pkg::num_warps; w++) begin
            head_hazard[w] = head[w].valid && (|(inuse_regs[w] & head[w].used_regs));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            inuse_regs <= '0;
        end else begin
            if (release_reg) begin
                inuse_regs[writeback.wid][writeback.rd] <= 1'b0;
            end
            // reserve comes last so it wins over a release of the same bit
            if (reserve_reg) begin
                inuse_regs[reserve_wid][res_head.rd] <= 1'b1;
            end
        end
    end

endmodule

/* design/warp_ibuffer.sv */
`timescale 1ns/1ns

module warp_ibuffer #(
    parameter int IBUF_DEPTH = 4
) (
    input  logic                                              clk,
    input  logic                                              reset,
    input  issue_pkg::decode_t                                decode_in,
    output logic                                              decode_ready,
    input  logic                                              pop,
    input  issue_pkg::wid_t                                   pop_wid,
    output issue_pkg::decode_t [issue_pkg::num_warps-1:0]     head
);

    localparam int ptr_w = (IBUF_DEPTH > 1) ? $clog2(IBUF_DEPTH) : 1;
    localparam int cnt_w = $clog2(IBUF_DEPTH + 1);

    issue_pkg::decode_t mem [issue_pkg::num_warps][IBUF_DEPTH];

    logic [ptr_w-1:0] rd_ptr [issue_pkg::num_warps];
    logic [ptr_w-1:0] wr_ptr [issue_pkg::num_warps];
    logic [cnt_w-1:0] count  [issue_pkg::num_warps];

    logic push;
    logic [issue_pkg::num_warps-1:0] push_w;
    logic [issue_pkg::num_warps-1:0] pop_w;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        logic [ptr_w-1:0] nxt;
        if (ptr == ptr_w'(IBUF_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // a full buffer of the addressed warp holds off the decoder
    assign decode_ready = (count[decode_in.wid] != cnt_w'(IBUF_DEPTH));
    assign push = decode_in.valid && decode_ready;

    always_comb begin
        for (int w = 0; w < issue_pkg::num_warps; w++) begin
            push_w[w] = push && (decode_in.wid == issue_pkg::wid_t'(w));
            pop_w[w]  = pop && (pop_wid == issue_pkg::wid_t'(w));
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < issue_pkg::num_warps; w++) begin
            if (push_w[w]) begin
                mem[w][wr_ptr[w]] <= decode_in;
            end
        end
    end

    // push and pop of the same warp may coincide, the count then holds
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < issue_pkg::num_warps; w++) begin
                rd_ptr[w] <= '0;
                wr_ptr[w] <= '0;
                count[w]  <= '0;
            end
        end else begin
            for (int w = 0; w < issue_pkg::num_warps; w++) begin
                if (push_w[w]) begin
                    wr_ptr[w] <= next_ptr(wr_ptr[w]);
                end
                if (pop_w[w]) begin
                    rd_ptr[w] <= next_ptr(rd_ptr[w]);
                end
                if (push_w[w] && !pop_w[w]) begin
                    count[w] <= count[w] + 1'b1;
                end else if (pop_w[w] && !push_w[w]) begin
                    count[w] <= count[w] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < issue_pkg::num_warps; w++) begin
            head[w]       = mem[w][rd_ptr[w]];
            head[w].valid = (count[w] != '0);
        end
    end

endmodule

/* filelist.f */
design/issue_pkg.sv
design/warp_ibuffer.sv
design/scoreboard.sv
design/operand_regfile.sv
design/issue_ctrl.sv
design/issue_stage.sv
testbench/issue_checker.sv
testbench/tb_issue_stage.sv

/* testbench/issue_checker.sv */
`timescale 1ns/1ns

module issue_checker #(
    parameter int IBUF_DEPTH  = 4,
    parameter int STALL_LIMIT = 16
) (
    input  logic                  clk,
    input  logic                  reset,
    input  issue_pkg::decode_t    decode_in,
    input  logic                  decode_ready,
    input  issue_pkg::writeback_t writeback,
    input  issue_pkg::issue_t     issue_out,
    input  logic                  issue_ready,
    input  logic                  stall_timeout,
    output int                    error_count,
    output int                    issue_count
);

    issue_pkg::decode_t pending [issue_pkg::num_warps][$];
    logic [31:0]        inuse [issue_pkg::num_warps];
    logic [31:0]        regs [issue_pkg::num_warps][issue_pkg::num_regs];
    int                 stall_cnt [issue_pkg::num_warps];
    issue_pkg::issue_t  prev_out;
    logic               prev_hold;
    int                 last_wid;

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("error: %0t ns %s expected %h actual %h", $time, name, exp_v, act_v);
        error_count++;
    endtask

    initial begin
        error_count = 0;
        issue_count = 0;
    end

    // everything is sampled at the rising edge, before the DUT registers move
    always @(posedge clk) begin : check
        logic [issue_pkg::num_warps-1:0] elig;
        logic [issue_pkg::num_warps-1:0] stalled;
        issue_pkg::decode_t              exp;
        logic                            fire;
        logic                            exp_timeout;
        logic                            exp_ready;
        int                              w;
        int                              pick;
        logic [31:0]                     exp_b;
        if (reset) begin
            for (int i = 0; i < issue_pkg::num_warps; i++) begin
                pending[i].delete();
                inuse[i]     = '0;
                stall_cnt[i] = 0;
                for (int r = 0; r < issue_pkg::num_regs; r++) begin
                    regs[i][r] = '0;
                end
            end
            prev_hold = 1'b0;
            last_wid  = issue_pkg::num_warps - 1;
        end else begin
            exp         = '0;
            exp_timeout = 1'b0;
            for (int i = 0; i < issue_pkg::num_warps; i++) begin
                stalled[i] = (pending[i].size() != 0) &&
                             ((inuse[i] & pending[i][0].used_regs) != 0);
                elig[i]    = (pending[i].size() != 0) && !stalled[i];
                if (stall_cnt[i] >= STALL_LIMIT) begin
                    exp_timeout = 1'b1;
                end
            end
            if (stall_timeout !== exp_timeout) begin
                report_mismatch("stall_timeout", exp_timeout, stall_timeout);
            end
            exp_ready = (pending[decode_in.wid].size() != IBUF_DEPTH);
            if (decode_ready !== exp_ready) begin
                report_mismatch("decode_ready", exp_ready, decode_ready);
            end
            if (prev_hold) begin
                if (issue_out !== prev_out) begin
                    $display("error: %0t ns issue_out changed while issue_ready was low",
                             $time);
                    error_count++;
                end
            end else begin
                pick = -1;
                for (int k = 1; k <= issue_pkg::num_warps; k++) begin
                    w = (last_wid + k) % issue_pkg::num_warps;
                    if (pick < 0 && elig[w]) begin
                        pick = w;
                    end
                end
                if (issue_out.valid !== (pick >= 0)) begin
                    report_mismatch("issue_out.valid", pick >= 0, issue_out.valid);
                end else if (pick >= 0 && issue_out.wid !== pick) begin
                    report_mismatch("issue_out.wid", pick, issue_out.wid);
                end
            end
            fire = issue_out.valid && issue_ready;
            if (fire) begin
                w = issue_out.wid;
                if (pending[w].size() == 0) begin
                    $display("error: %0t ns issue from warp %0d with nothing accepted",
                             $time, w);
                    error_count++;
                end else begin
                    exp = pending[w].pop_front();
                    exp_b = exp.use_imm ? 32'(exp.src_b) : regs[w][exp.src_b[4:0]];
                    if (issue_out.pc !== exp.pc) begin
                        report_mismatch("issue_out.pc", exp.pc, issue_out.pc);
                    end
                    if (issue_out.rd !== exp.rd) begin
                        report_mismatch("issue_out.rd", exp.rd, issue_out.rd);
                    end
                    if (issue_out.wb !== exp.wb) begin
                        report_mismatch("issue_out.wb", exp.wb, issue_out.wb);
                    end
                    if (issue_out.operand_a !== regs[w][exp.rs1]) begin
                        report_mismatch("issue_out.operand_a", regs[w][exp.rs1],
                                        issue_out.operand_a);
                    end
                    if (issue_out.operand_b !== exp_b) begin
                        report_mismatch("issue_out.operand_b", exp_b, issue_out.operand_b);
                    end
                end
                issue_count++;
                last_wid = w;
            end
            for (int i = 0; i < issue_pkg::num_warps; i++) begin
                if (fire && issue_out.wid == i) begin
                    stall_cnt[i] = 0;
                end else if (stalled[i] && stall_cnt[i] < STALL_LIMIT) begin
                    stall_cnt[i]++;
                end
            end
            if (writeback.valid) begin
                inuse[writeback.wid][writeback.rd] = 1'b0;
                regs[writeback.wid][writeback.rd]  = writeback.data;
            end
            // a reserve wins over a release of the same register
            if (fire && exp.wb) begin
                inuse[issue_out.wid][exp.rd] = 1'b1;
            end
            if (decode_in.valid && decode_ready) begin
                pending[decode_in.wid].push_back(decode_in);
            end
            prev_hold = issue_out.valid && !issue_ready;
            prev_out  = issue_out;
        end
    end

endmodule

/* testbench/tb_issue_stage.sv */
`timescale 1ns/1ns

module tb_issue_stage;

    localparam int limit_cycles = 100;

    typedef struct packed {
        issue_pkg::decode_t    dec;
        issue_pkg::writeback_t wb;
        logic                  ready;
        int                    idle;
        int                    wait_issues;
    } row_t;

    logic                  clk;
    logic                  reset;
    issue_pkg::decode_t    decode_in;
    logic                  decode_ready;
    issue_pkg::writeback_t writeback;
    issue_pkg::issue_t     issue_out;
    logic                  issue_ready;
    logic                  stall_timeout;
    int                    error_count;
    int                    issue_count;
    int                    tb_errors;
    logic                  stall_seen;
    logic                  stuck;
    row_t                  rows [$];

    issue_stage #(
        .IBUF_DEPTH  (4),
        .STALL_LIMIT (8)
    ) u_issue_stage (
        .clk           (clk),
        .reset         (reset),
        .decode_in     (decode_in),
        .decode_ready  (decode_ready),
        .writeback     (writeback),
        .issue_out     (issue_out),
        .issue_ready   (issue_ready),
        .stall_timeout (stall_timeout)
    );

    issue_checker #(
        .IBUF_DEPTH  (4),
        .STALL_LIMIT (8)
    ) u_issue_checker (
        .clk           (clk),
        .reset         (reset),
        .decode_in     (decode_in),
        .decode_ready  (decode_ready),
        .writeback     (writeback),
        .issue_out     (issue_out),
        .issue_ready   (issue_ready),
        .stall_timeout (stall_timeout),
        .error_count   (error_count),
        .issue_count   (issue_count)
    );

    always #10 clk = ~clk;

    always @(negedge clk) begin
        if (stall_timeout) begin
            stall_seen = 1'b1;
        end
    end

    // used_regs holds rs1, rs2 when no immediate is used, and rd when written
    function automatic issue_pkg::decode_t make_dec(input int wid, input int pc, input int rd,
                                                    input logic wb, input int rs1,
                                                    input logic use_imm,
                                                    input logic [31:0] src_b);
        issue_pkg::decode_t d;
        d         = '0;
        d.valid   = 1'b1;
        d.wid     = issue_pkg::wid_t'(wid);
        d.pc      = 32'(pc);
        d.rd      = issue_pkg::reg_idx_t'(rd);
        d.wb      = wb;
        d.rs1     = issue_pkg::reg_idx_t'(rs1);
        d.use_imm = use_imm;
        d.src_b   = src_b;
        d.used_regs[rs1] = 1'b1;
        if (!use_imm) begin
            d.used_regs[src_b[4:0]] = 1'b1;
        end
        if (wb) begin
            d.used_regs[rd] = 1'b1;
        end
        return d;
    endfunction

    task automatic add_dec(input issue_pkg::decode_t d, input logic ready, input int idle,
                           input int wait_issues);
        row_t r;
        r.dec         = d;
        r.wb          = '0;
        r.ready       = ready;
        r.idle        = idle;
        r.wait_issues = wait_issues;
        rows.push_back(r);
    endtask

    task automatic add_wb(input int wid, input int rd, input logic [31:0] data,
                          input int idle, input int wait_issues);
        row_t r;
        r.dec         = '0;
        r.wb.valid    = 1'b1;
        r.wb.wid      = issue_pkg::wid_t'(wid);
        r.wb.rd       = issue_pkg::reg_idx_t'(rd);
        r.wb.data     = data;
        r.ready       = 1'b1;
        r.idle        = idle;
        r.wait_issues = wait_issues;
        rows.push_back(r);
    endtask

    task automatic build_table;
        add_wb(0, 1, 32'h11, 0, 0);
        add_wb(0, 2, 32'h22, 0, 0);
        add_dec(make_dec(0, 'h100, 3, 1, 1, 0, 2), 1, 0, 0);
        add_dec(make_dec(0, 'h104, 4, 1, 2, 1, -5), 1, 0, 2);
        add_wb(0, 3, 32'h33, 0, 0);
        add_wb(0, 4, 32'h44, 0, 0);
        // read after write on r5, then write after write on r6
        add_dec(make_dec(0, 'h108, 5, 1, 1, 0, 2), 1, 0, 3);
        add_dec(make_dec(0, 'h10c, 6, 1, 5, 1, 7), 1, 3, 0);
        add_wb(0, 5, 32'h55, 0, 4);
        add_dec(make_dec(0, 'h110, 6, 1, 1, 1, 1), 1, 2, 0);
        add_wb(0, 6, 32'h66, 0, 5);
        // warp 0 blocked on r6 while the other warps go on
        add_dec(make_dec(0, 'h114, 7, 1, 6, 1, 0), 1, 0, 0);
        add_dec(make_dec(1, 'h200, 1, 1, 0, 1, 9), 1, 0, 6);
        add_dec(make_dec(1, 'h204, 2, 0, 0, 0, 3), 0, 0, 0);
        add_dec(make_dec(2, 'h300, 2, 1, 0, 1, 4), 0, 0, 0);
        add_dec(make_dec(3, 'h400, 3, 0, 0, 0, 0), 0, 2, 0);
        add_dec(make_dec(1, 'h208, 3, 0, 0, 1, 1), 1, 0, 10);
        add_wb(0, 6, 32'h77, 0, 11);
        // fill the warp 3 buffer while the consumer holds off
        add_dec(make_dec(3, 'h404, 0, 0, 3, 1, 1), 0, 0, 0);
        add_dec(make_dec(3, 'h408, 0, 0, 3, 1, 2), 0, 0, 0);
        add_dec(make_dec(3, 'h40c, 0, 0, 3, 1, 3), 0, 0, 0);
        add_dec(make_dec(3, 'h410, 0, 0, 3, 1, 4), 0, 1, 0);
        add_dec(make_dec(3, 'h414, 0, 0, 3, 1, 5), 1, 0, 16);
        // a long hazard trips the watchdog
        add_dec(make_dec(2, 'h500, 8, 1, 1, 1, 0), 1, 0, 17);
        add_dec(make_dec(2, 'h504, 9, 1, 8, 1, 0), 1, 12, 0);
        add_wb(2, 8, 32'h88, 3, 18);
    endtask

    task automatic apply_row(input row_t r, output logic timed_out);
        int cycles;
        timed_out = 1'b0;
        @(posedge clk);
        #2;
        decode_in   = r.dec;
        writeback   = r.wb;
        issue_ready = r.ready;
        cycles = 0;
        @(negedge clk);
        while (r.dec.valid && !decode_ready && !timed_out) begin
            cycles++;
            if (cycles > limit_cycles) begin
                $display("timeout while waiting for decode_ready");
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
        if (!timed_out) begin
            @(posedge clk);
            #2;
            decode_in.valid = 1'b0;
            writeback.valid = 1'b0;
            repeat (r.idle) @(posedge clk);
            cycles = 0;
            @(negedge clk);
            while (issue_count < r.wait_issues && !timed_out) begin
                cycles++;
                if (cycles > limit_cycles) begin
                    $display("timeout, instruction %0d was never issued", r.wait_issues);
                    timed_out = 1'b1;
                end else begin
                    @(negedge clk);
                end
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        decode_in   = '0;
        writeback   = '0;
        issue_ready = 1'b1;
        tb_errors   = 0;
        stall_seen  = 1'b0;
        stuck       = 1'b0;
        build_table();
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        foreach (rows[i]) begin
            if (!stuck) begin
                apply_row(rows[i], stuck);
            end
        end
        repeat (4) @(posedge clk);
        if (stuck) begin
            tb_errors++;
        end else if (!stall_seen) begin
            $display("stall_timeout never rose during the long hazard");
            tb_errors++;
        end
        $display("errors: checker %0d, testbench %0d, issues %0d",
                 error_count, tb_errors, issue_count);
        if (error_count == 0 && tb_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
